// File: filelist.f
+incdir+hdl
hdl/tlb_pkg.sv
hdl/tlb_csr.sv
hdl/tlb_array.sv
hdl/tlb_match.sv
hdl/tlb_lookup.sv
hdl/tlb_unit.sv
dv/tlb_assert.sv
dv/tlb_checker.sv
dv/tb_tlb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the TLB testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_tlb \
    -f filelist.f --Mdir "$BUILD_DIR" -o sim_tlb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tlb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

// File: dv/tb_tlb.sv
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tb_tlb import tlb_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        cfg_we;
    csr_addr_t   cfg_addr;
    addr_t       cfg_wdata;
    addr_t       cfg_rdata;
    logic        cmd_valid;
    tlb_cmd_e    cmd;
    logic [2:0]  inv_op;
    asid_t       inv_asid;
    addr_t       inv_va;
    logic        cmd_done;
    logic        lookup_valid;
    addr_t       lookup_va;
    logic        lookup_rsp_valid;
    lookup_rsp_t lookup_rsp;

    int          test_num;
    int          check_total;
    int          err_total;
    int          hs_fail;
    vppn_t       pool_vppn [`TLB_NUM];
    ps_t         pool_ps   [`TLB_NUM];
    // cycle budget of each test
    int          budget [5] = '{200, 400, 400, 300, 2000};

    tlb_unit i_tlb_unit (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg_we           (cfg_we),
        .cfg_addr         (cfg_addr),
        .cfg_wdata        (cfg_wdata),
        .cfg_rdata        (cfg_rdata),
        .cmd_valid        (cmd_valid),
        .cmd              (cmd),
        .inv_op           (inv_op),
        .inv_asid         (inv_asid),
        .inv_va           (inv_va),
        .cmd_done         (cmd_done),
        .lookup_valid     (lookup_valid),
        .lookup_va        (lookup_va),
        .lookup_rsp_valid (lookup_rsp_valid),
        .lookup_rsp       (lookup_rsp)
    );

    tlb_checker i_tlb_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .test_num         (test_num),
        .cfg_we           (cfg_we),
        .cfg_addr         (cfg_addr),
        .cfg_wdata        (cfg_wdata),
        .cfg_rdata        (cfg_rdata),
        .cmd_valid        (cmd_valid),
        .cmd              (cmd),
        .inv_op           (inv_op),
        .inv_asid         (inv_asid),
        .inv_va           (inv_va),
        .cmd_done         (cmd_done),
        .lookup_valid     (lookup_valid),
        .lookup_va        (lookup_va),
        .lookup_rsp_valid (lookup_rsp_valid),
        .lookup_rsp       (lookup_rsp),
        .check_total      (check_total),
        .err_total        (err_total)
    );

    always #50 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic reg_write(csr_addr_t a, addr_t d);
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        next_cycle();
        cfg_we    = 1'b0;
    endtask

    task automatic run_cmd(tlb_cmd_e c, logic [2:0] op, asid_t a, addr_t va);
        int n;
        cmd_valid = 1'b1;
        cmd       = c;
        inv_op    = op;
        inv_asid  = a;
        inv_va    = va;
        next_cycle();
        cmd_valid = 1'b0;
        cmd       = cmd_none;
        n = 0;
        while (!cmd_done && n < 4) begin
            next_cycle();
            n++;
        end
        if (!cmd_done) begin
            $display("command %s at %0t was never answered by cmd_done", c.name(), $time);
            hs_fail++;
        end
    endtask

    task automatic show_regs(int last);
        for (int a = 0; a <= last; a++) begin
            cfg_addr = csr_addr_t'(a);
            next_cycle();
        end
    endtask

    task automatic set_asid();
        reg_write(`CSR_ASID, 32'(1 + $urandom % 3));
    endtask

    // small vppn pool so that entries overlap and several can hit
    task automatic fill_table();
        for (int i = 0; i < `TLB_NUM; i++) begin
            pool_vppn[i] = {8'h0, 2'($urandom), 6'h0, 3'($urandom)};
            pool_ps[i]   = ($urandom % 2 == 0) ? `PS_4K : `PS_4M;
            set_asid();
            reg_write(`CSR_TLBEHI, {pool_vppn[i], 13'h0});
            reg_write(`CSR_TLBIDX, {($urandom % 6 == 0), 1'b0, pool_ps[i], 20'h0, 4'(i)});
            reg_write(`CSR_TLBELO0, $urandom);
            reg_write(`CSR_TLBELO1, $urandom);
            run_cmd(cmd_wr, 3'd0, '0, '0);
        end
    endtask

    task automatic read_entry(int i);
        reg_write(`CSR_TLBIDX, {28'h0, 4'(i)});
        run_cmd(cmd_rd, 3'd0, '0, '0);
        show_regs(4);
    endtask

    function automatic addr_t make_va();
        int    k;
        vppn_t vp;
        k  = $urandom % `TLB_NUM;
        vp = pool_vppn[k];
        if ($urandom % 5 == 0) begin
            vp = 19'($urandom);
        end else if (pool_ps[k] == `PS_4M) begin
            vp[8:0] = 9'($urandom);
        end
        return {vp, 13'($urandom)};
    endfunction

    task automatic lookup_burst(int n);
        for (int k = 0; k < n; k++) begin
            lookup_valid = 1'b1;
            lookup_va    = make_va();
            next_cycle();
            if (!lookup_rsp_valid) begin
                $display("lookup at %0t got no response in the next cycle", $time);
                hs_fail++;
            end
        end
        lookup_valid = 1'b0;
    endtask

    task automatic test_regs();
        test_num = 1;
        repeat (150) begin
            reg_write(csr_addr_t'($urandom % 8), $urandom);
        end
        show_regs(7);
    endtask

    task automatic test_entries();
        test_num = 2;
        fill_table();
        for (int i = 0; i < `TLB_NUM; i++) begin
            read_entry(i);
        end
    endtask

    task automatic test_lookups();
        test_num = 3;
        fill_table();
        repeat (30) begin
            set_asid();
            lookup_burst(1 + $urandom % 4);
            if ($urandom % 2 == 0) begin
                next_cycle();
            end
        end
    endtask

    task automatic test_search();
        vppn_t vp;
        int    k;
        test_num = 4;
        fill_table();
        repeat (40) begin
            k  = $urandom % `TLB_NUM;
            vp = pool_vppn[k];
            if ($urandom % 4 == 0) begin
                vp = 19'($urandom);
            end
            reg_write(`CSR_TLBEHI, {vp, 13'h0});
            set_asid();
            cfg_addr = `CSR_TLBIDX;
            run_cmd(cmd_srch, 3'd0, '0, '0);
        end
    endtask

    task automatic test_invalidate();
        test_num = 5;
        for (int op = 0; op < 8; op++) begin
            fill_table();
            set_asid();
            run_cmd(cmd_inv, 3'(op), 10'(1 + $urandom % 3), make_va());
            lookup_burst(8);
            for (int i = 0; i < `TLB_NUM; i++) begin
                read_entry(i);
            end
        end
    endtask

    initial begin
        int limit;
        limit = 16;
        foreach (budget[t]) begin
            limit += budget[t];
        end
        #(limit * 2 * 100);
        $display("watchdog expired: the run did not finish within %0d cycles", limit * 2);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int asrt;
        void'($urandom(32'h5444));
        clk          = 1'b0;
        rst_n        = 1'b0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        cmd_valid    = 1'b0;
        cmd          = cmd_none;
        inv_op       = '0;
        inv_asid     = '0;
        inv_va       = '0;
        lookup_valid = 1'b0;
        lookup_va    = '0;
        test_num     = 0;
        hs_fail      = 0;
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;
        next_cycle();
        test_regs();
        test_entries();
        test_lookups();
        test_search();
        test_invalidate();
        test_num = 0;
        next_cycle();
        next_cycle();
        asrt = i_tlb_unit.i_tlb_assert.fail_count;
        $display("tests 5, checks %0d, errors %0d, handshake failures %0d, assertion failures %0d",
                 check_total, err_total, hs_fail, asrt);
        if (err_total == 0 && hs_fail == 0 && asrt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

bind tlb_unit tlb_assert i_tlb_assert (
    .clk              (clk),
    .rst_n            (rst_n),
    .cmd_valid        (cmd_valid),
    .cmd_done         (cmd_done),
    .lookup_valid     (lookup_valid),
    .lookup_rsp_valid (lookup_rsp_valid)
);

// File: dv/tlb_checker.sv
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_checker import tlb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  int          test_num,
    input  logic        cfg_we,
    input  csr_addr_t   cfg_addr,
    input  addr_t       cfg_wdata,
    input  addr_t       cfg_rdata,
    input  logic        cmd_valid,
    input  tlb_cmd_e    cmd,
    input  logic [2:0]  inv_op,
    input  asid_t       inv_asid,
    input  addr_t       inv_va,
    input  logic        cmd_done,
    input  logic        lookup_valid,
    input  addr_t       lookup_va,
    input  logic        lookup_rsp_valid,
    input  lookup_rsp_t lookup_rsp,
    output int          check_total,
    output int          err_total
);

    // v, d, plv, mat, g and ppn
    localparam addr_t ELO_MASK = 32'h0fff_ff7f;

    asid_t       r_asid;
    vppn_t       r_vppn;
    tlb_idx_t    r_idx;
    ps_t         r_ps;
    logic        r_ne;
    addr_t       r_elo [2];

    // page words keep the entry-low layout with g cleared
    logic        m_e    [`TLB_NUM];
    vppn_t       m_vppn [`TLB_NUM];
    ps_t         m_ps   [`TLB_NUM];
    asid_t       m_asid [`TLB_NUM];
    logic        m_g    [`TLB_NUM];
    addr_t       m_lo   [`TLB_NUM][2];

    logic        exp_done;
    logic        exp_valid;
    lookup_rsp_t exp_rsp;
    int          cur_test;
    int          test_checks;
    int          test_errs;

    function automatic logic page_eq(int i, vppn_t vp);
        if (m_ps[i] == 6'd21) begin
            return m_vppn[i][18:9] == vp[18:9];
        end
        return m_vppn[i] == vp;
    endfunction

    function automatic int first_hit(vppn_t vp, asid_t as);
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (m_e[i] && (m_g[i] || m_asid[i] == as) && page_eq(i, vp)) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic addr_t reg_value(csr_addr_t a);
        case (a)
            3'd0:    return {22'h0, r_asid};
            3'd1:    return {r_vppn, 13'h0};
            3'd2:    return {r_ne, 1'b0, r_ps, 20'h0, r_idx};
            3'd3:    return r_elo[0];
            3'd4:    return r_elo[1];
            default: return '0;
        endcase
    endfunction

    function automatic lookup_rsp_t expect_lookup(addr_t va);
        lookup_rsp_t r;
        int          h;
        logic        odd;
        addr_t       w;
        r = '0;
        h = first_hit(va[31:13], r_asid);
        if (h >= 0) begin
            odd     = (m_ps[h] == 6'd21) ? va[21] : va[12];
            w       = m_lo[h][odd];
            r.found = 1'b1;
            r.pa    = (m_ps[h] == 6'd21) ? {w[27:17], va[20:0]} : {w[27:8], va[11:0]};
            r.plv   = w[3:2];
            r.mat   = w[5:4];
            r.d     = w[1];
            r.v     = w[0];
        end
        return r;
    endfunction

    function automatic logic inv_kills(int i);
        logic asid_eq;
        logic va_eq;
        asid_eq = m_asid[i] == inv_asid;
        va_eq   = page_eq(i, inv_va[31:13]);
        case (inv_op)
            3'd0, 3'd1: return 1'b1;
            3'd2:       return m_g[i];
            3'd3:       return !m_g[i];
            3'd4:       return !m_g[i] && asid_eq;
            3'd5:       return !m_g[i] && asid_eq && va_eq;
            3'd6:       return (m_g[i] || asid_eq) && va_eq;
            default:    return 1'b0;
        endcase
    endfunction

    task automatic apply_cmd();
        int h;
        case (cmd)
            cmd_wr: begin
                m_e[r_idx]     = !r_ne;
                m_vppn[r_idx]  = r_vppn;
                m_ps[r_idx]    = r_ps;
                m_asid[r_idx]  = r_asid;
                m_g[r_idx]     = r_elo[0][6] & r_elo[1][6];
                m_lo[r_idx][0] = r_elo[0] & ~32'h40;
                m_lo[r_idx][1] = r_elo[1] & ~32'h40;
            end
            cmd_rd: begin
                if (m_e[r_idx]) begin
                    r_ne     = 1'b0;
                    r_vppn   = m_vppn[r_idx];
                    r_ps     = m_ps[r_idx];
                    r_asid   = m_asid[r_idx];
                    r_elo[0] = m_lo[r_idx][0] | {25'h0, m_g[r_idx], 6'h0};
                    r_elo[1] = m_lo[r_idx][1] | {25'h0, m_g[r_idx], 6'h0};
                end else begin
                    r_ne     = 1'b1;
                    r_vppn   = '0;
                    r_ps     = '0;
                    r_elo[0] = '0;
                    r_elo[1] = '0;
                end
            end
            cmd_srch: begin
                h = first_hit(r_vppn, r_asid);
                if (h >= 0) begin
                    r_idx = tlb_idx_t'(h);
                    r_ne  = 1'b0;
                end else begin
                    r_ne = 1'b1;
                end
            end
            cmd_inv: begin
                for (int i = 0; i < `TLB_NUM; i++) begin
                    if (inv_kills(i)) begin
                        m_e[i] = 1'b0;
                    end
                end
            end
            default: ;
        endcase
    endtask

    task automatic tally(logic ok, string what, logic [63:0] got, logic [63:0] exp);
        check_total++;
        test_checks++;
        if (!ok) begin
            err_total++;
            test_errs++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        check_total = 0;
        err_total   = 0;
        cur_test    = 0;
        test_checks = 0;
        test_errs   = 0;
    end

    // model state moves on the same edge as the DUT
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_asid    = '0;
            r_vppn    = '0;
            r_idx     = '0;
            r_ps      = '0;
            r_ne      = 1'b0;
            r_elo[0]  = '0;
            r_elo[1]  = '0;
            exp_done  = 1'b0;
            exp_valid = 1'b0;
            for (int i = 0; i < `TLB_NUM; i++) begin
                m_e[i] = 1'b0;
            end
        end else begin
            exp_done  = cmd_valid;
            exp_valid = lookup_valid;
            if (lookup_valid) begin
                exp_rsp = expect_lookup(lookup_va);
            end
            if (cfg_we) begin
                case (cfg_addr)
                    `CSR_ASID:    r_asid = cfg_wdata[9:0];
                    `CSR_TLBEHI:  r_vppn = cfg_wdata[31:13];
                    `CSR_TLBIDX: begin
                        r_idx = cfg_wdata[3:0];
                        r_ps  = cfg_wdata[29:24];
                        r_ne  = cfg_wdata[31];
                    end
                    `CSR_TLBELO0: r_elo[0] = cfg_wdata & ELO_MASK;
                    `CSR_TLBELO1: r_elo[1] = cfg_wdata & ELO_MASK;
                    default: ;
                endcase
            end else if (cmd_valid) begin
                apply_cmd();
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (test_num != cur_test) begin
            if (cur_test != 0) begin
                $display("test %0d done: %0d checks, %0d errors",
                         cur_test, test_checks, test_errs);
            end
            cur_test    = test_num;
            test_checks = 0;
            test_errs   = 0;
        end
        if (rst_n) begin
            tally(cfg_rdata === reg_value(cfg_addr),
                  $sformatf("cfg_rdata at addr %0d", cfg_addr),
                  64'(cfg_rdata), 64'(reg_value(cfg_addr)));
            tally(cmd_done === exp_done, "cmd_done", 64'(cmd_done), 64'(exp_done));
            tally(lookup_rsp_valid === exp_valid, "lookup_rsp_valid",
                  64'(lookup_rsp_valid), 64'(exp_valid));
            if (exp_valid && lookup_rsp_valid) begin
                tally(lookup_rsp === exp_rsp, "lookup_rsp", 64'(lookup_rsp), 64'(exp_rsp));
            end
        end
    end

endmodule

// File: dv/tlb_assert.sv
`timescale 1ns/100ps

module tlb_assert (
    input logic clk,
    input logic rst_n,
    input logic cmd_valid,
    input logic cmd_done,
    input logic lookup_valid,
    input logic lookup_rsp_valid
);

    int fail_count = 0;

    // both strobes answer exactly one cycle later
    cmd_done_follows: assert property (
        @(posedge clk) disable iff (!rst_n) cmd_valid |=> cmd_done
    ) else begin
        $error("cmd_done did not follow cmd_valid");
        fail_count++;
    end

    cmd_done_alone: assert property (
        @(posedge clk) disable iff (!rst_n) !cmd_valid |=> !cmd_done
    ) else begin
        $error("cmd_done without a command");
        fail_count++;
    end

    rsp_follows: assert property (
        @(posedge clk) disable iff (!rst_n) lookup_valid |=> lookup_rsp_valid
    ) else begin
        $error("lookup_rsp_valid did not follow lookup_valid");
        fail_count++;
    end

    rsp_alone: assert property (
        @(posedge clk) disable iff (!rst_n) !lookup_valid |=> !lookup_rsp_valid
    ) else begin
        $error("lookup_rsp_valid without a request");
        fail_count++;
    end

    quiet_in_reset: assert property (
        @(posedge clk) !rst_n |-> !cmd_done && !lookup_rsp_valid
    ) else begin
        $error("strobe high during reset");
        fail_count++;
    end

endmodule

// File: hdl/tlb_unit.sv
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_unit import tlb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cfg_we,
    input  csr_addr_t   cfg_addr,
    input  addr_t       cfg_wdata,
    output addr_t       cfg_rdata,
    input  logic        cmd_valid,
    input  tlb_cmd_e    cmd,
    input  logic [2:0]  inv_op,
    input  asid_t       inv_asid,
    input  addr_t       inv_va,
    output logic        cmd_done,
    input  logic        lookup_valid,
    input  addr_t       lookup_va,
    output logic        lookup_rsp_valid,
    output lookup_rsp_t lookup_rsp
);

    tlb_entry_t [`TLB_NUM-1:0] entries;
    tlb_entry_t                rd_entry;
    tlb_entry_t                wr_entry;
    match_rsp_t                srch_rsp;
    match_rsp_t                lkup_rsp;
    vppn_t                     srch_vppn;
    asid_t                     cur_asid;
    tlb_idx_t                  idx;
    logic                      wr_en;
    logic                      inv_en;

    assign inv_en = cmd_valid && cmd == cmd_inv;

    tlb_csr i_tlb_csr (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .srch_rsp  (srch_rsp),
        .rd_entry  (rd_entry),
        .srch_vppn (srch_vppn),
        .cur_asid  (cur_asid),
        .idx       (idx),
        .wr_en     (wr_en),
        .wr_entry  (wr_entry)
    );

    tlb_array i_tlb_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .idx      (idx),
        .wr_entry (wr_entry),
        .inv_en   (inv_en),
        .inv_op   (inv_op),
        .inv_asid (inv_asid),
        .inv_va   (inv_va),
        .rd_entry (rd_entry),
        .entries  (entries)
    );

    // search path takes the page pair from entry-high
    tlb_match i_srch_match (
        .entries    (entries),
        .vppn       (srch_vppn),
        .odd_bit_va ({srch_vppn, 13'd0}),
        .asid       (cur_asid),
        .rsp        (srch_rsp)
    );

    tlb_match i_lkup_match (
        .entries    (entries),
        .vppn       (lookup_va[31:13]),
        .odd_bit_va (lookup_va),
        .asid       (cur_asid),
        .rsp        (lkup_rsp)
    );

    tlb_lookup i_tlb_lookup (
        .clk              (clk),
        .rst_n            (rst_n),
        .lookup_valid     (lookup_valid),
        .lookup_va        (lookup_va),
        .match            (lkup_rsp),
        .lookup_rsp_valid (lookup_rsp_valid),
        .lookup_rsp       (lookup_rsp)
    );

endmodule

// File: hdl/tlb_lookup.sv
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_lookup import tlb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        lookup_valid,
    input  addr_t       lookup_va,
    input  match_rsp_t  match,
    output logic        lookup_rsp_valid,
    output lookup_rsp_t lookup_rsp
);

    lookup_rsp_t rsp_d;
    lookup_rsp_t rsp_q;
    logic        valid_q;
    addr_t       pa;

    always_comb begin
        if (match.ps == `PS_4K) begin
            pa = {match.page.ppn, lookup_va[11:0]};
        end else begin
            pa = {match.page.ppn[19:9], lookup_va[20:0]};
        end
    end

    // miss returns an all-zero response
    always_comb begin
        rsp_d = '0;
        if (match.hit) begin
            rsp_d.found = 1'b1;
            rsp_d.pa    = pa;
            rsp_d.plv   = match.page.plv;
            rsp_d.mat   = match.page.mat;
            rsp_d.d     = match.page.d;
            rsp_d.v     = match.page.v;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            rsp_q <= rsp_d;
        end
    end

    assign lookup_rsp_valid = valid_q;
    assign lookup_rsp       = rsp_q;

endmodule

// File: hdl/tlb_match.sv
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_match import tlb_pkg::*; (
    input  tlb_entry_t [`TLB_NUM-1:0] entries,
    input  vppn_t                     vppn,
    input  addr_t                     odd_bit_va,
    input  asid_t                     asid,
    output match_rsp_t                rsp
);

    logic [`TLB_NUM-1:0] hit_vec;
    tlb_idx_t            hit_idx;
    tlb_entry_t          hit_entry;
    logic                odd;

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            hit_vec[i] = entries[i].e
                      && (entries[i].g || entries[i].asid == asid)
                      && vppn_match(entries[i].vppn, vppn, entries[i].ps);
        end
    end

    // scan downwards so the lowest hit is assigned last
    always_comb begin
        hit_idx = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    assign hit_entry = entries[hit_idx];
    assign odd       = (hit_entry.ps == `PS_4M) ? odd_bit_va[21] : odd_bit_va[12];

    always_comb begin
        rsp.hit   = |hit_vec;
        rsp.index = hit_idx;
        rsp.ps    = hit_entry.ps;
        rsp.page  = odd ? hit_entry.page1 : hit_entry.page0;
    end

endmodule

// File: hdl/tlb_array.sv
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_array import tlb_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  tlb_idx_t                      idx,
    input  tlb_entry_t                    wr_entry,
    input  logic                          inv_en,
    input  logic [2:0]                    inv_op,
    input  asid_t                         inv_asid,
    input  addr_t                         inv_va,
    output tlb_entry_t                    rd_entry,
    output tlb_entry_t [`TLB_NUM-1:0]     entries
);

    // e bits live apart from the entry payload
    tlb_entry_t [`TLB_NUM-1:0] mem_q;
    logic [`TLB_NUM-1:0]       e_q;
    logic [`TLB_NUM-1:0]       inv_hit;
    logic [`TLB_NUM-1:0]       asid_eq;
    logic [`TLB_NUM-1:0]       va_eq;
    logic                      inv_apply;
    vppn_t                     inv_vppn;

    assign inv_vppn  = inv_va[31:13];
    assign inv_apply = inv_en && (inv_op <= `INV_OP_MAX);

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            asid_eq[i] = mem_q[i].asid == inv_asid;
            va_eq[i]   = vppn_match(mem_q[i].vppn, inv_vppn, mem_q[i].ps);
            case (inv_op)
                3'd2:    inv_hit[i] = mem_q[i].g;
                3'd3:    inv_hit[i] = !mem_q[i].g;
                3'd4:    inv_hit[i] = !mem_q[i].g && asid_eq[i];
                3'd5:    inv_hit[i] = !mem_q[i].g && asid_eq[i] && va_eq[i];
                3'd6:    inv_hit[i] = (mem_q[i].g || asid_eq[i]) && va_eq[i];
                // ops 0 and 1 flush everything
                default: inv_hit[i] = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_q <= '0;
        end else if (wr_en) begin
            e_q[idx] <= wr_entry.e;
        end else if (inv_apply) begin
            e_q <= e_q & ~inv_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[idx] <= wr_entry;
        end
    end

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            entries[i]   = mem_q[i];
            entries[i].e = e_q[i];
        end
    end

    assign rd_entry = entries[idx];

endmodule

// File: hdl/tlb_csr.sv
`timescale 1ns/100ps
`include "tlb_defs.svh"

module tlb_csr import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_we,
    input  csr_addr_t  cfg_addr,
    input  addr_t      cfg_wdata,
    output addr_t      cfg_rdata,
    input  logic       cmd_valid,
    input  tlb_cmd_e   cmd,
    output logic       cmd_done,
    input  match_rsp_t srch_rsp,
    input  tlb_entry_t rd_entry,
    output vppn_t      srch_vppn,
    output asid_t      cur_asid,
    output tlb_idx_t   idx,
    output logic       wr_en,
    output tlb_entry_t wr_entry
);

    asid_t           asid_q;
    vppn_t           vppn_q;
    tlb_idx_t        idx_q;
    ps_t             ps_q;
    logic            ne_q;
    tlb_page_t [1:0] elo_q;
    logic [1:0]      elo_g_q;
    logic            done_q;

    function automatic addr_t elo_pack(tlb_page_t p, logic g);
        addr_t w;
        w = '0;
        w[`TLBELO_V] = p.v;
        w[`TLBELO_D] = p.d;
        w[`TLBELO_PLV_HI:`TLBELO_PLV_LO] = p.plv;
        w[`TLBELO_MAT_HI:`TLBELO_MAT_LO] = p.mat;
        w[`TLBELO_G] = g;
        w[`TLBELO_PPN_HI:`TLBELO_PPN_LO] = p.ppn;
        return w;
    endfunction

    function automatic tlb_page_t elo_page(addr_t w);
        tlb_page_t p;
        p.v   = w[`TLBELO_V];
        p.d   = w[`TLBELO_D];
        p.plv = w[`TLBELO_PLV_HI:`TLBELO_PLV_LO];
        p.mat = w[`TLBELO_MAT_HI:`TLBELO_MAT_LO];
        p.ppn = w[`TLBELO_PPN_HI:`TLBELO_PPN_LO];
        return p;
    endfunction

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            `CSR_ASID:    cfg_rdata[`ASID_ASID_HI:`ASID_ASID_LO] = asid_q;
            `CSR_TLBEHI:  cfg_rdata[`TLBEHI_VPPN_HI:`TLBEHI_VPPN_LO] = vppn_q;
            `CSR_TLBIDX: begin
                cfg_rdata[`TLBIDX_IDX_HI:`TLBIDX_IDX_LO] = idx_q;
                cfg_rdata[`TLBIDX_PS_HI:`TLBIDX_PS_LO] = ps_q;
                cfg_rdata[`TLBIDX_NE] = ne_q;
            end
            `CSR_TLBELO0: cfg_rdata = elo_pack(elo_q[0], elo_g_q[0]);
            `CSR_TLBELO1: cfg_rdata = elo_pack(elo_q[1], elo_g_q[1]);
            default:      cfg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            asid_q  <= '0;
            vppn_q  <= '0;
            idx_q   <= '0;
            ps_q    <= '0;
            ne_q    <= 1'b0;
            elo_q   <= '0;
            elo_g_q <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                `CSR_ASID:   asid_q <= cfg_wdata[`ASID_ASID_HI:`ASID_ASID_LO];
                `CSR_TLBEHI: vppn_q <= cfg_wdata[`TLBEHI_VPPN_HI:`TLBEHI_VPPN_LO];
                `CSR_TLBIDX: begin
                    idx_q <= cfg_wdata[`TLBIDX_IDX_HI:`TLBIDX_IDX_LO];
                    ps_q  <= cfg_wdata[`TLBIDX_PS_HI:`TLBIDX_PS_LO];
                    ne_q  <= cfg_wdata[`TLBIDX_NE];
                end
                `CSR_TLBELO0: begin
                    elo_q[0]   <= elo_page(cfg_wdata);
                    elo_g_q[0] <= cfg_wdata[`TLBELO_G];
                end
                `CSR_TLBELO1: begin
                    elo_q[1]   <= elo_page(cfg_wdata);
                    elo_g_q[1] <= cfg_wdata[`TLBELO_G];
                end
                default: ;
            endcase
        end else if (cmd_valid && cmd == cmd_srch) begin
            if (srch_rsp.hit) begin
                idx_q <= srch_rsp.index;
                ne_q  <= 1'b0;
            end else begin
                ne_q <= 1'b1;
            end
        end else if (cmd_valid && cmd == cmd_rd) begin
            if (rd_entry.e) begin
                ne_q     <= 1'b0;
                vppn_q   <= rd_entry.vppn;
                ps_q     <= rd_entry.ps;
                asid_q   <= rd_entry.asid;
                elo_q[0] <= rd_entry.page0;
                elo_q[1] <= rd_entry.page1;
                elo_g_q  <= {2{rd_entry.g}};
            end else begin
                // empty slot leaves asid unchanged
                ne_q    <= 1'b1;
                vppn_q  <= '0;
                ps_q    <= '0;
                elo_q   <= '0;
                elo_g_q <= '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= cmd_valid;
        end
    end

    assign cmd_done  = done_q;
    assign srch_vppn = vppn_q;
    assign cur_asid  = asid_q;
    assign idx       = idx_q;
    assign wr_en     = cmd_valid && cmd == cmd_wr;

    always_comb begin
        wr_entry.e     = ~ne_q;
        wr_entry.vppn  = vppn_q;
        wr_entry.ps    = ps_q;
        wr_entry.asid  = asid_q;
        wr_entry.g     = &elo_g_q;
        wr_entry.page0 = elo_q[0];
        wr_entry.page1 = elo_q[1];
    end

endmodule

// File: hdl/tlb_pkg.sv
`include "tlb_defs.svh"

package tlb_pkg;

    typedef logic [18:0]            vppn_t;
    typedef logic [9:0]             asid_t;
    typedef logic [19:0]            ppn_t;
    typedef logic [5:0]             ps_t;
    typedef logic [1:0]             plv_t;
    typedef logic [1:0]             mat_t;
    typedef logic [`TLB_IDX_W-1:0]  tlb_idx_t;
    typedef logic [31:0]            addr_t;
    typedef logic [2:0]             csr_addr_t;

    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_page_t;

    typedef struct packed {
        logic      e;
        vppn_t     vppn;
        ps_t       ps;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef enum logic [2:0] {
        cmd_none,
        cmd_srch,
        cmd_rd,
        cmd_wr,
        cmd_inv
    } tlb_cmd_e;

    typedef struct packed {
        logic  found;
        addr_t pa;
        plv_t  plv;
        mat_t  mat;
        logic  d;
        logic  v;
    } lookup_rsp_t;

    typedef struct packed {
        logic      hit;
        tlb_idx_t  index;
        ps_t       ps;
        tlb_page_t page;
    } match_rsp_t;

    // large pages only compare the upper vppn bits
    function automatic logic vppn_match(vppn_t ent_vppn, vppn_t req_vppn, ps_t ps);
        if (ps == `PS_4M) begin
            return ent_vppn[18:9] == req_vppn[18:9];
        end
        return ent_vppn == req_vppn;
    endfunction

endpackage

// File: hdl/tlb_defs.svh
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

`define TLB_NUM         16
`define TLB_IDX_W       4

// legal page sizes
`define PS_4K           6'd12
`define PS_4M           6'd21

`define CSR_ASID        3'd0
`define CSR_TLBEHI      3'd1
`define CSR_TLBIDX      3'd2
`define CSR_TLBELO0     3'd3
`define CSR_TLBELO1     3'd4

`define ASID_ASID_HI    9
`define ASID_ASID_LO    0

`define TLBEHI_VPPN_HI  31
`define TLBEHI_VPPN_LO  13

`define TLBIDX_IDX_HI   (`TLB_IDX_W - 1)
`define TLBIDX_IDX_LO   0
`define TLBIDX_PS_HI    29
`define TLBIDX_PS_LO    24
`define TLBIDX_NE       31

`define TLBELO_V        0
`define TLBELO_D        1
`define TLBELO_PLV_HI   3
`define TLBELO_PLV_LO   2
`define TLBELO_MAT_HI   5
`define TLBELO_MAT_LO   4
`define TLBELO_G        6
`define TLBELO_PPN_HI   27
`define TLBELO_PPN_LO   8

`define INV_OP_MAX      3'd6

`endif
